/* runner_pkg.sv */
package runner_pkg;

    localparam int COORD_W = 12;

    typedef enum logic [1:0] {
        WAITING    = 2'd0,
        RUNNING    = 2'd1,
        CRASHED    = 2'd2,
        RESTARTING = 2'd3
    } game_state_t;

    // Pixel speed times SPEED_SCALE
    typedef logic [14:0] speed_t;

    // Frame index within one second
    typedef logic [5:0] frame_timer_t;

    // 0 is day, 255 is full night
    typedef logic [7:0] night_rate_t;

    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        logic [COORD_W-1:0] w;
        logic [COORD_W-1:0] h;
    } collision_box_t;

    localparam int SPEED_SCALE = 1024;

    localparam speed_t START_SPEED  = speed_t'(6 * SPEED_SCALE);
    localparam speed_t MAX_SPEED    = speed_t'(13 * SPEED_SCALE);
    localparam speed_t ACCELERATION = speed_t'(1);

    localparam night_rate_t MAX_NIGHT_RATE   = 8'd255;
    localparam night_rate_t NIGHT_RATE_DELTA = 8'd5;

    // Strict overlap, so shared edges and empty boxes never collide
    function automatic logic boxes_overlap(collision_box_t a, collision_box_t b);
        logic [COORD_W:0] a_right;
        logic [COORD_W:0] a_bottom;
        logic [COORD_W:0] b_right;
        logic [COORD_W:0] b_bottom;
        logic             non_empty;
        a_right   = {1'b0, a.x} + {1'b0, a.w};
        a_bottom  = {1'b0, a.y} + {1'b0, a.h};
        b_right   = {1'b0, b.x} + {1'b0, b.w};
        b_bottom  = {1'b0, b.y} + {1'b0, b.h};
        non_empty = (a.w != '0) && (a.h != '0) && (b.w != '0) && (b.h != '0);
        return non_empty
            && ({1'b0, a.x} < b_right)
            && ({1'b0, b.x} < a_right)
            && ({1'b0, a.y} < b_bottom)
            && ({1'b0, b.y} < a_bottom);
    endfunction

endpackage

/* frame_pacer.sv */
`timescale 1ns/100ps

module frame_pacer #(
    parameter int FPS = 60
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      painter_finished,
    output logic                      update,
    output runner_pkg::frame_timer_t  timer
);

    localparam runner_pkg::frame_timer_t LAST_FRAME = runner_pkg::frame_timer_t'(FPS - 1);

    logic painter_finished_last;
    logic frame_done;

    // Painter finished a frame since the last sample
    assign frame_done = painter_finished && !painter_finished_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            painter_finished_last <= 1'b0;
            update                <= 1'b0;
            timer                 <= '0;
        end else begin
            painter_finished_last <= painter_finished;
            update                <= frame_done;

            if (frame_done) begin
                if (timer == LAST_FRAME) begin
                    timer <= '0;
                end else begin
                    timer <= timer + 1'b1;
                end
            end
        end
    end

endmodule

/* collision_detector.sv */
`timescale 1ns/100ps

module collision_detector #(
    parameter int TREX_BOXES     = 4,
    parameter int OBSTACLE_BOXES = 6
) (
    input  logic                       clk,
    input  logic                       rst,
    input  runner_pkg::collision_box_t trex_box [TREX_BOXES],
    input  runner_pkg::collision_box_t obstacle_box [OBSTACLE_BOXES],
    output logic                       crashed
);

    logic [TREX_BOXES-1:0] trex_hit;
    logic                  any_hit;

    // Per dinosaur box, does it touch any obstacle box
    always_comb begin
        for (int i = 0; i < TREX_BOXES; i++) begin
            trex_hit[i] = 1'b0;
            for (int j = 0; j < OBSTACLE_BOXES; j++) begin
                if (runner_pkg::boxes_overlap(trex_box[i], obstacle_box[j])) begin
                    trex_hit[i] = 1'b1;
                end
            end
        end
    end

    assign any_hit = |trex_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            crashed <= 1'b0;
        end else begin
            crashed <= any_hit;
        end
    end

endmodule

/* game_fsm.sv */
`timescale 1ns/100ps

module game_fsm #(
    parameter int CLEAR_TIME = 180
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     update,
    input  logic                     jumping,
    input  logic                     crashed,
    output runner_pkg::game_state_t  state,
    output logic                     start,
    output logic                     restart,
    output logic                     has_obstacles,
    output runner_pkg::speed_t       speed,
    output logic                     run_step
);

    // Wide enough to hold CLEAR_TIME + 1
    localparam int CT_W = $clog2(CLEAR_TIME + 2);

    runner_pkg::game_state_t next_state;

    logic [CT_W-1:0] clear_timer;
    logic            jumping_last;
    logic            run_update;

    always_comb begin
        next_state = state;
        case (state)
            runner_pkg::WAITING: begin
                if (update && jumping) begin
                    next_state = runner_pkg::RUNNING;
                end
            end
            runner_pkg::RUNNING: begin
                if (crashed) begin
                    next_state = runner_pkg::CRASHED;
                end
            end
            runner_pkg::CRASHED: begin
                // Needs a fresh press, not a held jump
                if (jumping && !jumping_last) begin
                    next_state = runner_pkg::RESTARTING;
                end
            end
            runner_pkg::RESTARTING: begin
                if (!jumping) begin
                    next_state = runner_pkg::WAITING;
                end
            end
            default: begin
                next_state = runner_pkg::WAITING;
            end
        endcase
    end

    // Frame in which the game is or becomes running
    assign run_update = update && (next_state == runner_pkg::RUNNING);

    // Starting frame is excluded
    assign run_step = run_update && (state == runner_pkg::RUNNING);

    assign restart = (state == runner_pkg::RESTARTING);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= runner_pkg::WAITING;
            jumping_last <= 1'b0;
        end else begin
            state        <= next_state;
            jumping_last <= jumping;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start         <= 1'b0;
            speed         <= '0;
            clear_timer   <= '0;
            has_obstacles <= 1'b0;
        end else if (next_state == runner_pkg::RESTARTING) begin
            start         <= 1'b0;
            speed         <= '0;
            clear_timer   <= '0;
            has_obstacles <= 1'b0;
        end else if (run_update) begin
            if (state == runner_pkg::WAITING) begin
                start <= 1'b1;
                speed <= runner_pkg::START_SPEED;
            end else begin
                clear_timer <= clear_timer + 1'b1;
                if (clear_timer > CT_W'(CLEAR_TIME)) begin
                    has_obstacles <= 1'b1;
                end

                // Ramp until the ceiling
                if (speed <= runner_pkg::MAX_SPEED - runner_pkg::ACCELERATION) begin
                    speed <= speed + runner_pkg::ACCELERATION;
                end
            end
        end
    end

endmodule

/* night_fade.sv */
`timescale 1ns/100ps

module night_fade #(
    parameter int INVERT_FADE_DURATION = 720
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     update,
    input  logic                     run_step,
    input  logic                     restart,
    input  logic                     invert_trigger,
    output runner_pkg::night_rate_t  night_rate
);

    localparam int IT_W = $clog2(INVERT_FADE_DURATION + 1);

    logic            inverted;
    logic [IT_W-1:0] invert_timer;

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            inverted     <= 1'b0;
            invert_timer <= '0;
            night_rate   <= '0;
        end else begin
            // Fade one step per frame, using the flag from before this edge
            if (update) begin
                if (inverted && night_rate < runner_pkg::MAX_NIGHT_RATE) begin
                    night_rate <= night_rate + runner_pkg::NIGHT_RATE_DELTA;
                end else if (!inverted && night_rate > '0) begin
                    night_rate <= night_rate - runner_pkg::NIGHT_RATE_DELTA;
                end
            end

            // Night lasts a fixed number of running frames
            if (run_step) begin
                if (invert_timer == IT_W'(INVERT_FADE_DURATION)) begin
                    invert_timer <= '0;
                    inverted     <= 1'b0;
                end else if (inverted) begin
                    invert_timer <= invert_timer + 1'b1;
                end else if (invert_trigger) begin
                    inverted <= 1'b1;
                end
            end
        end
    end

endmodule

/* runner_top.sv */
`timescale 1ns/100ps

module runner_top #(
    parameter int FPS                  = 60,
    parameter int CLEAR_TIME           = 180,
    parameter int INVERT_FADE_DURATION = 720,
    parameter int TREX_BOXES           = 4,
    parameter int OBSTACLE_BOXES       = 6
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       jumping,
    input  logic                       painter_finished,
    input  logic                       invert_trigger,
    input  runner_pkg::collision_box_t trex_box [TREX_BOXES],
    input  runner_pkg::collision_box_t obstacle_box [OBSTACLE_BOXES],
    output runner_pkg::game_state_t    state,
    output logic                       update,
    output logic                       start,
    output logic                       restart,
    output logic                       has_obstacles,
    output runner_pkg::frame_timer_t   timer,
    output runner_pkg::speed_t         speed,
    output runner_pkg::night_rate_t    night_rate
);

    logic crashed;
    logic run_step;

    frame_pacer #(
        .FPS(FPS)
    ) u_frame_pacer (
        .clk              (clk),
        .rst              (rst),
        .painter_finished (painter_finished),
        .update           (update),
        .timer            (timer)
    );

    collision_detector #(
        .TREX_BOXES     (TREX_BOXES),
        .OBSTACLE_BOXES (OBSTACLE_BOXES)
    ) u_collision_detector (
        .clk          (clk),
        .rst          (rst),
        .trex_box     (trex_box),
        .obstacle_box (obstacle_box),
        .crashed      (crashed)
    );

    game_fsm #(
        .CLEAR_TIME(CLEAR_TIME)
    ) u_game_fsm (
        .clk           (clk),
        .rst           (rst),
        .update        (update),
        .jumping       (jumping),
        .crashed       (crashed),
        .state         (state),
        .start         (start),
        .restart       (restart),
        .has_obstacles (has_obstacles),
        .speed         (speed),
        .run_step      (run_step)
    );

    night_fade #(
        .INVERT_FADE_DURATION(INVERT_FADE_DURATION)
    ) u_night_fade (
        .clk            (clk),
        .rst            (rst),
        .update         (update),
        .run_step       (run_step),
        .restart        (restart),
        .invert_trigger (invert_trigger),
        .night_rate     (night_rate)
    );

endmodule

/* runner_assertions.sv */
`timescale 1ns/100ps

module runner_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    update,
    input logic                    restart,
    input logic                    has_obstacles,
    input runner_pkg::game_state_t state,
    input runner_pkg::speed_t      speed,
    input runner_pkg::night_rate_t night_rate
);

    int error_count = 0;

    // Frame strobe is a single pulse
    update_single: assert property (@(posedge clk) disable iff (rst) update |=> !update)
        else begin
            error_count++;
            $error("update was high on two consecutive cycles");
        end

    // Restart wipes the game and the fade in both modules
    restart_clears: assert property (
        @(posedge clk) disable iff (rst)
        restart |=> speed == '0 && !has_obstacles && night_rate == '0)
        else begin
            error_count++;
            $error("restart left speed, has_obstacles or night_rate set");
        end

    speed_ceiling: assert property (
        @(posedge clk) disable iff (rst) speed <= runner_pkg::MAX_SPEED)
        else begin
            error_count++;
            $error("speed is above the ceiling");
        end

    // Speed is loaded on the same edge that enters RUNNING
    running_speed: assert property (
        @(posedge clk) disable iff (rst) state == runner_pkg::RUNNING |-> speed != '0)
        else begin
            error_count++;
            $error("state is RUNNING with zero speed");
        end

endmodule

bind runner_top runner_assertions u_assertions (.*);

/* tb_runner.sv */
`timescale 1ns/100ps

module tb_runner;

    localparam int CLK_PERIOD     = 40;
    localparam int FPS            = 60;
    localparam int CLEAR_TIME     = 8;
    localparam int FADE_DURATION  = 12;
    localparam int TREX_BOXES     = 4;
    localparam int OBSTACLE_BOXES = 6;
    localparam int CYCLES_PER_ROW = 6;

    typedef enum int {SEL_APART, SEL_TOUCH, SEL_OVERLAP} box_sel_t;

    typedef struct {
        logic                    jump;
        logic                    invert;
        box_sel_t                boxes;
        logic                    frame;
        runner_pkg::game_state_t exp_state;
        logic                    exp_obstacles;
    } row_t;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       jumping;
    logic                       painter_finished;
    logic                       invert_trigger;
    runner_pkg::collision_box_t trex_box [TREX_BOXES];
    runner_pkg::collision_box_t obstacle_box [OBSTACLE_BOXES];
    runner_pkg::game_state_t    state;
    logic                       update;
    logic                       start;
    logic                       restart;
    logic                       has_obstacles;
    runner_pkg::frame_timer_t   timer;
    runner_pkg::speed_t         speed;
    runner_pkg::night_rate_t    night_rate;

    row_t        rows [$];
    logic [31:0] rng_state = 32'd62483;
    bit          table_ready = 1'b0;

    // Expected game as the testbench sees it
    runner_pkg::game_state_t  m_state;
    runner_pkg::speed_t       m_speed;
    runner_pkg::night_rate_t  m_rate;
    runner_pkg::frame_timer_t m_timer;
    logic                     m_start;
    logic                     m_inverted;
    logic                     m_jump_last;
    int                       m_invert_timer;

    runner_top #(
        .FPS                  (FPS),
        .CLEAR_TIME           (CLEAR_TIME),
        .INVERT_FADE_DURATION (FADE_DURATION),
        .TREX_BOXES           (TREX_BOXES),
        .OBSTACLE_BOXES       (OBSTACLE_BOXES)
    ) DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic runner_pkg::collision_box_t make_box(int x, int y, int w, int h);
        runner_pkg::collision_box_t b;
        b.x = 12'(x);
        b.y = 12'(y);
        b.w = 12'(w);
        b.h = 12'(h);
        return b;
    endfunction

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_state(string what, runner_pkg::game_state_t got,
                               runner_pkg::game_state_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
            stop_on_failure();
        end
    endtask

    task automatic check_speed(string what, runner_pkg::speed_t got, runner_pkg::speed_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_rate(string what, runner_pkg::night_rate_t got,
                              runner_pkg::night_rate_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_timer(string what, runner_pkg::frame_timer_t got,
                               runner_pkg::frame_timer_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // Boxes move a little every row but keep their class
    task automatic set_boxes(box_sel_t sel);
        int dx;
        int dy;
        rng_state = xorshift(rng_state);
        dx = int'(rng_state[2:0]);
        dy = int'(rng_state[7:4]);
        for (int i = 0; i < TREX_BOXES; i++) begin
            trex_box[i] = make_box(20 + 20 * i + dx, 40 + dy, 8, 12);
        end
        for (int j = 0; j < OBSTACLE_BOXES; j++) begin
            obstacle_box[j] = make_box(300 + 40 * j + int'(rng_state[11:8]), 40, 10, 20);
        end
        // Empty box inside the first dinosaur box
        obstacle_box[OBSTACLE_BOXES-1] = make_box(22 + dx, 40 + dy, 0, 10);
        if (sel == SEL_TOUCH) begin
            obstacle_box[0] = make_box(28 + dx, 40 + dy, 10, 10);
            obstacle_box[1] = make_box(40 + dx, 52 + dy, 5, 5);
        end else if (sel == SEL_OVERLAP) begin
            obstacle_box[0] = make_box(61 + dx + int'(rng_state[13:12]), 45 + dy, 4, 4);
        end
    endtask

    task automatic add_rows(int n, logic j, logic inv, box_sel_t sel, logic frm,
                            runner_pkg::game_state_t st, logic obs);
        row_t r;
        r = '{j, inv, sel, frm, st, obs};
        repeat (n) rows.push_back(r);
    endtask

    // Jump edges act on the first edge of a row and the frame strobe on the second
    task automatic model_row(row_t r);
        logic step;
        step = 1'b0;
        if (m_state == runner_pkg::CRASHED && r.jump && !m_jump_last) begin
            m_state = runner_pkg::RESTARTING;
        end else if (m_state == runner_pkg::RESTARTING && !r.jump) begin
            m_state = runner_pkg::WAITING;
        end
        if (m_state == runner_pkg::RESTARTING) begin
            m_speed        = '0;
            m_start        = 1'b0;
            m_rate         = '0;
            m_inverted     = 1'b0;
            m_invert_timer = 0;
        end else begin
            if (r.frame && m_inverted && m_rate < runner_pkg::MAX_NIGHT_RATE) begin
                m_rate = m_rate + runner_pkg::NIGHT_RATE_DELTA;
            end else if (r.frame && !m_inverted && m_rate > 0) begin
                m_rate = m_rate - runner_pkg::NIGHT_RATE_DELTA;
            end
            if (m_state == runner_pkg::RUNNING && r.boxes == SEL_OVERLAP) begin
                m_state = runner_pkg::CRASHED;
            end else if (m_state == runner_pkg::WAITING && r.frame && r.jump) begin
                m_state = runner_pkg::RUNNING;
                m_speed = runner_pkg::START_SPEED;
                m_start = 1'b1;
            end else if (m_state == runner_pkg::RUNNING && r.frame) begin
                step = 1'b1;
                if (int'(m_speed) + int'(runner_pkg::ACCELERATION)
                        <= int'(runner_pkg::MAX_SPEED)) begin
                    m_speed = m_speed + runner_pkg::ACCELERATION;
                end
            end
            if (step && m_invert_timer == FADE_DURATION) begin
                m_invert_timer = 0;
                m_inverted     = 1'b0;
            end else if (step && m_inverted) begin
                m_invert_timer++;
            end else if (step && r.invert) begin
                m_inverted = 1'b1;
            end
        end
        if (r.frame) m_timer = (int'(m_timer) == FPS - 1) ? '0 : m_timer + 1'b1;
        m_jump_last = r.jump;
    endtask

    initial begin
        longint limit;
        wait (table_ready);
        limit = 2 * longint'(rows.size()) * CYCLES_PER_ROW * CLK_PERIOD;
        #(limit);
        $display("The run timed out after %0d ns before the stimulus table was done", limit);
        stop_on_failure();
    end

    initial begin
        rst              = 1'b1;
        jumping          = 1'b0;
        painter_finished = 1'b0;
        invert_trigger   = 1'b0;
        set_boxes(SEL_APART);
        {m_start, m_inverted, m_jump_last} = 3'b0;
        m_state        = runner_pkg::WAITING;
        m_speed        = '0;
        m_rate         = '0;
        m_timer        = '0;
        m_invert_timer = 0;

        // count, jump, invert, boxes, frame, state, has_obstacles
        add_rows(2,  0, 0, SEL_APART,   0, runner_pkg::WAITING,    0);
        add_rows(1,  0, 0, SEL_APART,   1, runner_pkg::WAITING,    0);
        add_rows(1,  1, 0, SEL_APART,   1, runner_pkg::RUNNING,    0);
        add_rows(5,  0, 0, SEL_APART,   1, runner_pkg::RUNNING,    0);
        add_rows(4,  0, 0, SEL_TOUCH,   1, runner_pkg::RUNNING,    0);
        add_rows(1,  0, 0, SEL_TOUCH,   1, runner_pkg::RUNNING,    1);
        add_rows(1,  0, 0, SEL_APART,   0, runner_pkg::RUNNING,    1);
        add_rows(1,  0, 1, SEL_APART,   1, runner_pkg::RUNNING,    1);
        add_rows(13, 0, 0, SEL_APART,   1, runner_pkg::RUNNING,    1);
        add_rows(3,  0, 0, SEL_TOUCH,   1, runner_pkg::RUNNING,    1);
        add_rows(1,  0, 1, SEL_APART,   1, runner_pkg::RUNNING,    1);
        add_rows(1,  0, 0, SEL_OVERLAP, 1, runner_pkg::CRASHED,    1);
        add_rows(60, 0, 0, SEL_APART,   1, runner_pkg::CRASHED,    1);
        add_rows(1,  1, 0, SEL_APART,   0, runner_pkg::RESTARTING, 0);
        add_rows(1,  1, 0, SEL_APART,   1, runner_pkg::RESTARTING, 0);
        add_rows(1,  0, 0, SEL_APART,   0, runner_pkg::WAITING,    0);
        add_rows(1,  1, 0, SEL_APART,   1, runner_pkg::RUNNING,    0);
        add_rows(2,  0, 0, SEL_APART,   1, runner_pkg::RUNNING,    0);
        add_rows(1,  1, 0, SEL_OVERLAP, 0, runner_pkg::CRASHED,    0);
        add_rows(1,  1, 0, SEL_APART,   0, runner_pkg::CRASHED,    0);
        add_rows(1,  0, 0, SEL_APART,   0, runner_pkg::CRASHED,    0);
        add_rows(1,  1, 0, SEL_APART,   0, runner_pkg::RESTARTING, 0);
        add_rows(1,  0, 0, SEL_APART,   0, runner_pkg::WAITING,    0);
        table_ready = 1'b1;

        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        check_state("state after reset", state, runner_pkg::WAITING);
        check_flag("update after reset", update, 1'b0);
        check_flag("start after reset", start, 1'b0);
        check_flag("restart after reset", restart, 1'b0);
        check_flag("has_obstacles after reset", has_obstacles, 1'b0);
        check_speed("speed after reset", speed, '0);
        check_rate("night_rate after reset", night_rate, '0);
        check_timer("timer after reset", timer, '0);

        foreach (rows[k]) begin
            jumping          = rows[k].jump;
            invert_trigger   = rows[k].invert;
            painter_finished = rows[k].frame;
            set_boxes(rows[k].boxes);
            model_row(rows[k]);
            for (int c = 0; c < CYCLES_PER_ROW; c++) begin
                @(posedge clk);
                #1;
                // One strobe per painter frame however long it is held
                check_flag("update", update, rows[k].frame && c == 0);
                if (c == 2) begin
                    #1;
                    painter_finished = 1'b0;
                end
            end
            check_state("state", state, rows[k].exp_state);
            check_flag("has_obstacles", has_obstacles, rows[k].exp_obstacles);
            check_flag("restart", restart, m_state == runner_pkg::RESTARTING);
            check_flag("start", start, m_start);
            check_speed("speed", speed, m_speed);
            check_rate("night_rate", night_rate, m_rate);
            check_timer("timer", timer, m_timer);
            #1;
        end

        if (DUT.u_assertions.error_count != 0) begin
            $display("Bound assertions reported %0d failures", DUT.u_assertions.error_count);
            stop_on_failure();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* project.f */
runner_pkg.sv
frame_pacer.sv
collision_detector.sv
game_fsm.sv
night_fade.sv
runner_top.sv
runner_assertions.sv
tb_runner.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_runner -f project.f -o sim_runner
./obj_dir/sim_runner > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
